// File: softex_pkg.sv
//////////////////////////////////////////////////
// shared constants and vector types for the
// softmax row accumulator
//////////////////////////////////////////////////

package softex_pkg;

    // rows processed side by side
    localparam int unsigned NUM_ROWS        = 4;

    // bfloat16 layout
    localparam int unsigned BF16_WIDTH      = 16;
    localparam int unsigned BF16_MAN_BITS   = 7;
    localparam int unsigned BF16_EXP_BITS   = 8;
    localparam int unsigned BF16_BIAS       = 127;

    // fixed point sum, bit 23 weighs one
    localparam int unsigned ACC_WIDTH       = 24;

    // leading-zero count over ACC_WIDTH
    localparam int unsigned LZ_WIDTH        = 5;

    // one bfloat16 value: sign, exponent, mantissa
    typedef logic [BF16_WIDTH-1:0]  bf16_t;

    // one fixed point row sum
    typedef logic [ACC_WIDTH-1:0]   acc_t;

    // one bit per row
    typedef logic [NUM_ROWS-1:0]    row_strb_t;

    typedef logic [LZ_WIDTH-1:0]    lz_t;

endpackage

// File: softex_stream_ifs.sv
//////////////////////////////////////////////////
// internal valid/ready links: products and sums
//////////////////////////////////////////////////

`timescale 1ns/1ps

// multiplier to accumulator
interface softex_prod_if;
    import softex_pkg::*;

    logic                   valid;
    logic                   ready;
    bf16_t [NUM_ROWS-1:0]   prod;
    row_strb_t              strb;
    logic                   last;       // closes the group
    row_strb_t              positive;

    modport sender   (output valid, prod, strb, last, positive, input  ready);
    modport receiver (input  valid, prod, strb, last, positive, output ready);
endinterface

// accumulator holding register to normalizer
interface softex_sum_if;
    import softex_pkg::*;

    logic                   valid;
    logic                   ready;
    acc_t [NUM_ROWS-1:0]    sum;
    row_strb_t              strb;
    row_strb_t              positive;

    modport sender   (output valid, sum, strb, positive, input  ready);
    modport receiver (input  valid, sum, strb, positive, output ready);
endinterface

// File: softex_in_mul.sv
//////////////////////////////////////////////////
// input side: operand/weight join and per-row
// bfloat16 multiply into one register stage
//////////////////////////////////////////////////

`timescale 1ns/1ps

module softex_in_mul (
    input  logic                                        clk_i,
    input  logic                                        rst_i,
    input  logic                                        clear_i,
    input  logic                                        op_valid_i,
    input  logic                                        weight_valid_i,
    input  logic                                        last_weight_i,
    output logic                                        op_ready_o,
    output logic                                        weight_ready_o,
    input  softex_pkg::bf16_t [softex_pkg::NUM_ROWS-1:0] op_i,
    input  softex_pkg::bf16_t                           weight_i,
    input  softex_pkg::row_strb_t                       op_positive_i,
    input  softex_pkg::row_strb_t                       strb_i,
    output logic                                        busy_o,
    softex_prod_if.sender                               prod
);
    import softex_pkg::*;

    logic                   in_free;
    logic                   accept;
    bf16_t [NUM_ROWS-1:0]   prod_d;

    // stage can load when empty or drained this cycle
    assign in_free        = ~prod.valid | prod.ready;
    assign accept         = op_valid_i & weight_valid_i & in_free;

    // each ready waits on the other stream's valid
    assign op_ready_o     = weight_valid_i & in_free;
    assign weight_ready_o = op_valid_i & in_free;

    always_comb begin
        logic [2*BF16_MAN_BITS+1:0] sig_prod;
        logic [BF16_EXP_BITS+1:0]   exp_sum;
        logic [BF16_MAN_BITS-1:0]   man;
        logic                       guard;
        logic                       sticky;
        logic                       rnd;

        for (int r = 0; r < NUM_ROWS; r++) begin
            sig_prod = {1'b1, weight_i[BF16_MAN_BITS-1:0]} * {1'b1, op_i[r][BF16_MAN_BITS-1:0]};
            exp_sum  = {2'b00, weight_i[BF16_WIDTH-2 -: BF16_EXP_BITS]}
                     + {2'b00, op_i[r][BF16_WIDTH-2 -: BF16_EXP_BITS]}
                     - (BF16_EXP_BITS+2)'(BF16_BIAS);

            if (sig_prod[2*BF16_MAN_BITS+1]) begin    // product in [2,4)
                man     = sig_prod[2*BF16_MAN_BITS -: BF16_MAN_BITS];
                guard   = sig_prod[BF16_MAN_BITS];
                sticky  = |sig_prod[BF16_MAN_BITS-1:0];
                exp_sum = exp_sum + 1'b1;
            end else begin
                man     = sig_prod[2*BF16_MAN_BITS-1 -: BF16_MAN_BITS];
                guard   = sig_prod[BF16_MAN_BITS-1];
                sticky  = |sig_prod[BF16_MAN_BITS-2:0];
            end

            // nearest even, carry may reach the exponent
            rnd       = guard & (sticky | man[0]);
            prod_d[r] = {weight_i[BF16_WIDTH-1] ^ op_i[r][BF16_WIDTH-1],
                         {exp_sum[BF16_EXP_BITS-1:0], man} + (BF16_WIDTH-1)'(rnd)};

            // masked rows and zero inputs
            if (!strb_i[r] || weight_i[BF16_WIDTH-2 -: BF16_EXP_BITS] == '0
                    || op_i[r][BF16_WIDTH-2 -: BF16_EXP_BITS] == '0) begin
                prod_d[r] = '0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i || clear_i) begin
            prod.valid <= 1'b0;
        end else if (in_free) begin
            prod.valid <= accept;
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            prod.prod     <= prod_d;
            prod.strb     <= strb_i;
            prod.last     <= last_weight_i;
            prod.positive <= op_positive_i;
        end
    end

    assign busy_o = prod.valid;

endmodule

// File: softex_row_acc.sv
//////////////////////////////////////////////////
// processing side: bfloat16 to fixed point, row
// accumulators and the completed-sum register
//////////////////////////////////////////////////

`timescale 1ns/1ps

module softex_row_acc (
    input  logic            clk_i,
    input  logic            rst_i,
    input  logic            clear_i,
    output logic            busy_o,
    softex_prod_if.receiver prod,
    softex_sum_if.sender    sum
);
    import softex_pkg::*;

    acc_t [NUM_ROWS-1:0]    acc_q;
    acc_t [NUM_ROWS-1:0]    acc_d;
    logic                   take;

    // products are assumed positive and below one
    always_comb begin
        logic [ACC_WIDTH:0]         pre_shift;
        logic [ACC_WIDTH:0]         fix_shift;
        logic [BF16_EXP_BITS-1:0]   shamt;
        acc_t                       fix;

        for (int r = 0; r < NUM_ROWS; r++) begin
            shamt     = BF16_EXP_BITS'(BF16_BIAS) - prod.prod[r][BF16_WIDTH-2 -: BF16_EXP_BITS];
            pre_shift = {1'b1, prod.prod[r][BF16_MAN_BITS-1:0],
                         {(ACC_WIDTH-BF16_MAN_BITS){1'b0}}};
            fix_shift = pre_shift >> shamt;

            // drop the extra bit, round half up
            fix       = fix_shift[ACC_WIDTH:1] + ACC_WIDTH'(fix_shift[0]);
            acc_d[r]  = acc_q[r] + fix;     // wraps mod 2^24
        end
    end

    // a last product needs room in the holding register
    assign prod.ready = ~prod.last | ~sum.valid | sum.ready;
    assign take       = prod.valid & prod.ready;

    always_ff @(posedge clk_i) begin
        if (rst_i || clear_i) begin
            acc_q <= '0;
        end else if (take) begin
            if (prod.last) begin
                acc_q <= '0;            // next group starts clean
            end else begin
                acc_q <= acc_d;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i || clear_i) begin
            sum.valid <= 1'b0;
        end else if (take && prod.last) begin
            sum.valid <= 1'b1;
        end else if (sum.ready) begin
            sum.valid <= 1'b0;
        end
    end

    // completed group
    always_ff @(posedge clk_i) begin
        if (take && prod.last) begin
            sum.sum      <= acc_d;
            sum.strb     <= prod.strb;
            sum.positive <= prod.positive;
        end
    end

    // a group of all-zero addends looks idle
    assign busy_o = sum.valid | (acc_q != '0);

endmodule

// File: softex_fp_norm.sv
//////////////////////////////////////////////////
// output side: complement, leading-zero count,
// bfloat16 rounding and result register
//////////////////////////////////////////////////

`timescale 1ns/1ps

module softex_fp_norm (
    input  logic                                        clk_i,
    input  logic                                        rst_i,
    input  logic                                        clear_i,
    softex_sum_if.receiver                              sum,
    output logic                                        valid_o,
    input  logic                                        ready_i,
    output softex_pkg::bf16_t [softex_pkg::NUM_ROWS-1:0] res_o,
    output softex_pkg::row_strb_t                       strb_o,
    output logic                                        busy_o
);
    import softex_pkg::*;

    acc_t [NUM_ROWS-1:0]    int_res;
    acc_t [NUM_ROWS-1:0]    shifted;
    lz_t  [NUM_ROWS-1:0]    lz;
    bf16_t [NUM_ROWS-1:0]   res_d;

    always_comb begin
        logic [BF16_EXP_BITS-1:0]   exp_v;
        logic [BF16_WIDTH-2:0]      exp_man;

        for (int r = 0; r < NUM_ROWS; r++) begin
            // one minus sum for positive rows
            if (sum.positive[r]) begin
                int_res[r] = (acc_t'(1) << (ACC_WIDTH-1)) - sum.sum[r];
            end else begin
                int_res[r] = sum.sum[r];
            end

            // highest set bit wins
            lz[r] = '0;
            for (int b = 0; b < ACC_WIDTH; b++) begin
                if (int_res[r][b]) begin
                    lz[r] = lz_t'(ACC_WIDTH-1-b);
                end
            end

            shifted[r] = int_res[r] << (lz[r] + 1);     // hidden one out
            exp_v      = BF16_EXP_BITS'(BF16_BIAS - lz[r]);

            // half-up on the next bit
            exp_man    = {exp_v, shifted[r][ACC_WIDTH-1 -: BF16_MAN_BITS]}
                       + (BF16_WIDTH-1)'(shifted[r][ACC_WIDTH-1-BF16_MAN_BITS]);

            if (int_res[r] == '0) begin
                res_d[r] = '0;
            end else begin
                res_d[r] = {1'b0, exp_man};
            end
        end
    end

    assign sum.ready = ~valid_o | ready_i;

    always_ff @(posedge clk_i) begin
        if (rst_i || clear_i) begin
            valid_o <= 1'b0;
        end else if (sum.ready) begin
            valid_o <= sum.valid;
        end
    end

    // held while ready_i is low
    always_ff @(posedge clk_i) begin
        if (sum.valid && sum.ready) begin
            res_o  <= res_d;
            strb_o <= sum.strb;
        end
    end

    assign busy_o = valid_o;

endmodule

// File: softex_row_acc_top.sv
//////////////////////////////////////////////////
// row accumulator top: multiply, accumulate and
// normalize stages
//////////////////////////////////////////////////

`timescale 1ns/1ps

module softex_row_acc_top (
    input  logic                                        clk_i,
    input  logic                                        rst_i,
    input  logic                                        clear_i,
    input  logic                                        op_valid_i,
    input  logic                                        weight_valid_i,
    input  logic                                        last_weight_i,
    input  logic                                        ready_i,
    input  softex_pkg::bf16_t [softex_pkg::NUM_ROWS-1:0] op_i,
    input  softex_pkg::bf16_t                           weight_i,
    input  softex_pkg::row_strb_t                       op_positive_i,
    input  softex_pkg::row_strb_t                       strb_i,
    output logic                                        op_ready_o,
    output logic                                        weight_ready_o,
    output logic                                        valid_o,
    output logic                                        busy_o,
    output softex_pkg::bf16_t [softex_pkg::NUM_ROWS-1:0] res_o,
    output softex_pkg::row_strb_t                       strb_o
);

    logic mul_busy;
    logic acc_busy;
    logic norm_busy;

    softex_prod_if prod_if ();
    softex_sum_if  sum_if ();

    softex_in_mul i_in_mul (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .clear_i        (clear_i),
        .op_valid_i     (op_valid_i),
        .weight_valid_i (weight_valid_i),
        .last_weight_i  (last_weight_i),
        .op_ready_o     (op_ready_o),
        .weight_ready_o (weight_ready_o),
        .op_i           (op_i),
        .weight_i       (weight_i),
        .op_positive_i  (op_positive_i),
        .strb_i         (strb_i),
        .busy_o         (mul_busy),
        .prod           (prod_if.sender)
    );

    softex_row_acc i_row_acc (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .clear_i (clear_i),
        .busy_o  (acc_busy),
        .prod    (prod_if.receiver),
        .sum     (sum_if.sender)
    );

    softex_fp_norm i_fp_norm (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .clear_i (clear_i),
        .sum     (sum_if.receiver),
        .valid_o (valid_o),
        .ready_i (ready_i),
        .res_o   (res_o),
        .strb_o  (strb_o),
        .busy_o  (norm_busy)
    );

    assign busy_o = mul_busy | acc_busy | norm_busy;

endmodule

// File: tb_softex_properties.sv
//////////////////////////////////////////////////
// handshake assertions bound to the top level
//////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_softex_properties (
    input logic                                         clk_i,
    input logic                                         rst_i,
    input logic                                         clear_i,
    input logic                                         weight_valid_i,
    input logic                                         op_ready_o,
    input logic                                         valid_o,
    input logic                                         ready_i,
    input softex_pkg::bf16_t [softex_pkg::NUM_ROWS-1:0] res_o,
    input softex_pkg::row_strb_t                        strb_o
);

    int unsigned fail_count = 0;    // failed assertions so far

    // stalled result must not move
    a_hold_stable: assert property (
        @(posedge clk_i) disable iff (rst_i || clear_i)
        valid_o && !ready_i |=> valid_o && $stable(res_o) && $stable(strb_o)
    ) else begin
        $error("result changed while ready_i was low");
        fail_count++;
    end

    a_join: assert property (@(posedge clk_i) op_ready_o |-> weight_valid_i)
        else begin
            $error("op_ready_o high without weight_valid_i");
            fail_count++;
        end

    // reset and clear empty the output stage
    a_flush: assert property (@(posedge clk_i) (rst_i || clear_i) |=> !valid_o)
        else begin
            $error("valid_o high right after reset or clear");
            fail_count++;
        end

endmodule

bind softex_row_acc_top tb_softex_properties i_props (.*);

// File: tb_softex_row_acc.sv
//////////////////////////////////////////////////
// testbench: stimulus table, reference model,
// random stalls and clear check
//////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_softex_row_acc;
    import softex_pkg::*;

    localparam int MAX_PAIRS  = 64;
    localparam int MAX_GROUPS = 16;
    localparam int TIMEOUT    = 4000;

    logic clk_i = 1'b0;
    logic rst_i, clear_i, op_valid_i, weight_valid_i, last_weight_i, ready_i;
    logic op_ready_o, weight_ready_o, valid_o, busy_o;
    bf16_t [NUM_ROWS-1:0] op_i;
    bf16_t [NUM_ROWS-1:0] res_o;
    bf16_t                weight_i;
    row_strb_t            op_positive_i, strb_i, strb_o;

    // stimulus table and expected results per group
    bf16_t [NUM_ROWS-1:0] tab_op [MAX_PAIRS];
    bf16_t                tab_w [MAX_PAIRS];
    row_strb_t            tab_pos [MAX_PAIRS];
    row_strb_t            tab_strb [MAX_PAIRS];
    logic                 tab_last [MAX_PAIRS];
    bf16_t [NUM_ROWS-1:0] exp_res [MAX_GROUPS];
    row_strb_t            exp_strb [MAX_GROUPS];
    int                   grp_first [MAX_GROUPS+1];
    int                   npairs, ngroups;
    acc_t [NUM_ROWS-1:0]  model_acc;
    logic [31:0]          lfsr_q;

    softex_row_acc_top UUT (.*);

    always #50 clk_i = ~clk_i;

    always @(negedge clk_i) begin
        if (UUT.i_props.fail_count != 0) begin
            abort_run("a bound handshake assertion failed");
        end
    end

    function automatic logic lfsr_bit();
        logic fb;
        fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
        lfsr_q = {lfsr_q[30:0], fb};
        return fb;
    endfunction

    function automatic int unsigned rand_bits(input int n);
        int unsigned v;
        v = 0;
        for (int i = 0; i < n; i++) v = (v << 1) | lfsr_bit();
        return v;
    endfunction

    // bfloat16 product, nearest even
    function automatic bf16_t mul_model(input bf16_t a, input bf16_t b);
        int unsigned sig, e, sh, keep, rem, half, rnd;
        if (a[14:7] == 0 || b[14:7] == 0) return '0;
        sig = (128 + a[6:0]) * (128 + b[6:0]);
        e   = a[14:7] + b[14:7] - BF16_BIAS;
        sh  = BF16_MAN_BITS;
        if (sig >= (1 << (2*BF16_MAN_BITS+1))) begin     // renormalize by one bit
            sh = BF16_MAN_BITS + 1;
            e  = e + 1;
        end
        keep = sig >> sh;
        rem  = sig & ((1 << sh) - 1);
        half = 1 << (sh - 1);
        rnd  = (rem > half || (rem == half && keep % 2 == 1)) ? 1 : 0;
        return {a[15] ^ b[15], 15'((e << BF16_MAN_BITS) + (keep - 128) + rnd)};
    endfunction

    // value times 2^23, half up on the first dropped bit
    function automatic acc_t to_fixed(input bf16_t p);
        longint v;
        int     k;
        if (p[14:7] == 0) return '0;
        v = 128 + p[6:0];
        k = int'(BF16_BIAS + BF16_MAN_BITS - (ACC_WIDTH - 1)) - int'(p[14:7]);
        if (k <= 0) v = v << -k;
        else v = (v + (longint'(1) << (k - 1))) >> k;
        return acc_t'(v);
    endfunction

    function automatic bf16_t norm_model(input acc_t s, input logic pos);
        acc_t        v;
        acc_t        t;
        lz_t         lz;
        int unsigned e;
        v = pos ? acc_t'((1 << (ACC_WIDTH-1)) - s) : s;
        if (v == '0) return '0;
        lz = '0;
        while (!v[ACC_WIDTH-1-lz]) lz++;
        t = v << lz;                    // leading one now at bit 23
        e = BF16_BIAS - lz;
        return {1'b0, 15'((e << BF16_MAN_BITS) + t[22:16] + t[15])};
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1, "run aborted");
    endtask

    task automatic compare_values(input string what, input logic [63:0] got,
                                  input logic [63:0] exp);
        if (got !== exp) begin
            $display("ERR %0t ns: %s mismatch, got %h expected %h", $time, what, got, exp);
            abort_run("a DUT output did not match the model");
        end
    endtask

    task automatic add_pair(input bf16_t [NUM_ROWS-1:0] ops, input bf16_t w,
                            input row_strb_t pos, input row_strb_t strb, input logic last);
        tab_op[npairs]   = ops;
        tab_w[npairs]    = w;
        tab_pos[npairs]  = pos;
        tab_strb[npairs] = strb;
        tab_last[npairs] = last;
        npairs++;
        for (int r = 0; r < NUM_ROWS; r++) begin
            if (strb[r]) model_acc[r] = model_acc[r] + to_fixed(mul_model(w, ops[r]));
        end
        if (last) begin
            for (int r = 0; r < NUM_ROWS; r++) exp_res[ngroups][r] = norm_model(model_acc[r], pos[r]);
            model_acc          = '0;
            exp_strb[ngroups]  = strb;
            ngroups++;
            grp_first[ngroups] = npairs;
        end
    endtask

    task automatic build_table();
        bf16_t [NUM_ROWS-1:0] ops;
        int                   n;
        int unsigned          e;
        npairs       = 0;
        ngroups      = 0;
        grp_first[0] = 0;
        model_acc    = '0;
        add_pair({16'h3F40, 16'h3E80, 16'h3F7F, 16'h3D23}, 16'h3F00, 4'h0, 4'hF, 1'b1);
        add_pair({16'h3F10, 16'h3E55, 16'h3DA0, 16'h3F66}, 16'h3F20, 4'h0, 4'hF, 1'b0);
        add_pair({16'h3E01, 16'h3F7F, 16'h3C33, 16'h3E90}, 16'h3E90, 4'h0, 4'hF, 1'b0);
        add_pair({16'h3F00, 16'h3D10, 16'h3F45, 16'h3B80}, 16'h3F55, 4'h0, 4'hF, 1'b1);
        // row 0 sums to one exactly, complement gives zero
        for (int k = 0; k < 4; k++) begin
            add_pair({16'h3C80, 16'h3F00, 16'h3E80, 16'h3F00}, 16'h3F00, 4'b0011, 4'hF, k == 3);
        end
        add_pair({16'h3F30, 16'h3E70, 16'h3F08, 16'h3D50}, 16'h3F40, 4'h0, 4'b0101, 1'b0);
        add_pair({16'h3E20, 16'h3F11, 16'h3E99, 16'h3F7A}, 16'h3F10, 4'h0, 4'b1110, 1'b0);
        add_pair({16'h3D44, 16'h3F22, 16'h3E66, 16'h3F01}, 16'h3F70, 4'b0100, 4'b1010, 1'b1);
        for (int g = 0; g < MAX_GROUPS - 4; g++) begin
            n = 1 + rand_bits(2);
            for (int k = 0; k < n; k++) begin
                for (int r = 0; r < NUM_ROWS; r++) begin
                    e = 96 + rand_bits(5);
                    if (e > 126) e = 126;       // keep operands below one
                    ops[r] = {1'b0, 8'(e), 7'(rand_bits(7))};
                end
                add_pair(ops, {1'b0, 8'(119 + rand_bits(3)), 7'(rand_bits(7))},
                         4'(rand_bits(4)), 4'(rand_bits(4)), k == n - 1);
            end
        end
    endtask

    // called at a rising edge, sees the values before it
    task automatic drive_inputs(inout int p, input int p_end, input bit stall_en);
        bit accepted;
        bit keep_op;
        bit keep_w;
        accepted = op_valid_i && op_ready_o;
        keep_op  = op_valid_i && !accepted;
        keep_w   = weight_valid_i && !accepted;
        // the join opens both sides together
        if (!op_valid_i) begin
            compare_values("weight_ready_o without op_valid_i", weight_ready_o, 0);
        end else if (weight_valid_i) begin
            compare_values("weight_ready_o against op_ready_o", weight_ready_o, op_ready_o);
        end
        if (accepted) p++;
        if (p < p_end) begin
            op_i           <= tab_op[p];
            weight_i       <= tab_w[p];
            op_positive_i  <= tab_pos[p];
            strb_i         <= tab_strb[p];
            last_weight_i  <= tab_last[p];
            op_valid_i     <= keep_op || !stall_en || lfsr_bit();
            weight_valid_i <= keep_w || !stall_en || lfsr_bit();
        end else begin
            op_valid_i     <= 1'b0;
            weight_valid_i <= 1'b0;
        end
        ready_i <= !stall_en || (rand_bits(2) != 0);
    endtask

    task automatic run_groups(input int g_lo, input int g_hi, input bit stall_en);
        int                   p;
        int                   g_out;
        int                   cycles;
        bit                   held;
        bf16_t [NUM_ROWS-1:0] held_res;
        row_strb_t            held_strb;
        p      = grp_first[g_lo];
        g_out  = g_lo;
        cycles = 0;
        held   = 1'b0;
        while (g_out <= g_hi) begin
            @(posedge clk_i);
            if (held) begin
                compare_values("stalled valid_o", valid_o, 1);
                compare_values("stalled res_o", res_o, held_res);
                compare_values("stalled strb_o", strb_o, held_strb);
            end
            held      = valid_o && !ready_i;
            held_res  = res_o;
            held_strb = strb_o;
            if (valid_o && ready_i) begin
                compare_values($sformatf("res_o group %0d", g_out), res_o, exp_res[g_out]);
                compare_values($sformatf("strb_o group %0d", g_out), strb_o, exp_strb[g_out]);
                g_out++;
            end
            drive_inputs(p, grp_first[g_hi+1], stall_en);
            cycles++;
            if (cycles > TIMEOUT) begin
                abort_run($sformatf("timeout: result of group %0d never appeared", g_out));
            end
        end
        ready_i <= 1'b1;
        repeat (8) begin
            @(posedge clk_i);
            compare_values("valid_o while idle", valid_o, 0);
        end
        compare_values("busy_o while idle", busy_o, 0);
    endtask

    // valid_o should rise on the third edge after the pair is driven
    task automatic measure_latency();
        int p;
        int n;
        p = grp_first[0];
        n = 0;
        @(posedge clk_i);
        drive_inputs(p, grp_first[1], 1'b0);
        while (!valid_o) begin
            @(posedge clk_i);
            drive_inputs(p, grp_first[1], 1'b0);
            n++;
            if (n > 20) abort_run("timeout: valid_o never rose for the single-pair group");
        end
        compare_values("latency in cycles", n - 1, 3);
        compare_values("res_o single pair", res_o, exp_res[0]);
        compare_values("strb_o single pair", strb_o, exp_strb[0]);
    endtask

    task automatic clear_mid_group();
        int p;
        int cycles;
        p      = grp_first[1];
        cycles = 0;
        while (p < grp_first[1] + 2) begin
            @(posedge clk_i);
            drive_inputs(p, grp_first[1] + 2, 1'b0);
            cycles++;
            if (cycles > 50) abort_run("timeout: partial group pairs were never accepted");
        end
        repeat (2) @(posedge clk_i);
        compare_values("busy_o before clear", busy_o, 1);
        clear_i <= 1'b1;
        @(posedge clk_i);
        clear_i <= 1'b0;
        @(posedge clk_i);
        compare_values("busy_o after clear", busy_o, 0);
        compare_values("valid_o after clear", valid_o, 0);
    endtask

    initial begin
        rst_i          = 1'b1;
        clear_i        = 1'b0;
        op_valid_i     = 1'b0;
        weight_valid_i = 1'b0;
        last_weight_i  = 1'b0;
        ready_i        = 1'b1;
        op_i           = '0;
        weight_i       = '0;
        op_positive_i  = '0;
        strb_i         = '0;
        lfsr_q         = 32'h56c1;
        build_table();
        repeat (2) @(posedge clk_i);
        rst_i <= 1'b0;
        measure_latency();
        run_groups(1, ngroups - 1, 1'b0);
        run_groups(0, ngroups - 1, 1'b1);
        clear_mid_group();
        run_groups(1, 1, 1'b0);         // fresh group after the discarded one
        @(negedge clk_i);
        if (UUT.i_props.fail_count != 0) begin
            abort_run("a bound handshake assertion failed");
        end else begin
            $display("Simulation completed successfully");
            $finish;
        end
    end

endmodule

// File: filelist.f
softex_pkg.sv
softex_stream_ifs.sv
softex_in_mul.sv
softex_row_acc.sv
softex_fp_norm.sv
softex_row_acc_top.sv
tb_softex_properties.sv
tb_softex_row_acc.sv
